// File: logic/l1_cache_pkg.sv
`default_nettype none

package l1_cache_pkg;

    // cache geometry
    localparam int WORD_W     = 32;
    localparam int N_SETS     = 16;
    localparam int BLOCK_SIZE = 2;                 // words per block
    localparam int SET_BITS   = $clog2(N_SETS);
    localparam int BLOCK_BITS = $clog2(BLOCK_SIZE);
    localparam int BYTE_BITS  = 2;
    localparam int TAG_BITS   = WORD_W - SET_BITS - BLOCK_BITS - BYTE_BITS;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [WORD_W-1:0]     addr_t;
    typedef logic [WORD_W/8-1:0]   byte_en_t;      // one bit per byte lane
    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [SET_BITS-1:0]   set_idx_t;
    typedef logic [BLOCK_BITS-1:0] word_sel_t;

    // index of the final word in a block
    localparam word_sel_t LAST_WORD = word_sel_t'(BLOCK_SIZE - 1);

    // controller states
    typedef enum logic [2:0] {
        INIT,       // clear all frames after reset
        LOOKUP,     // tag compare, hits served here
        FETCH,      // block fill from memory
        WRITEBACK,  // dirty victim out to memory
        FLUSH       // walk all sets, write back and invalidate
    } cache_state_t;

endpackage

`default_nettype wire

// File: logic/cache_frame_array.sv
`timescale 1ns/1ns
`default_nettype none

module cache_frame_array (
    input  logic                   CLK,
    input  logic                   nRST,
    input  l1_cache_pkg::set_idx_t set_sel,
    input  logic                   wr_en,
    input  logic                   wr_valid,
    input  logic                   wr_dirty,
    input  l1_cache_pkg::tag_t     wr_tag,
    input  l1_cache_pkg::word_t    wr_data0,
    input  l1_cache_pkg::word_t    wr_data1,
    input  logic                   mask_valid,
    input  logic                   mask_dirty,
    input  logic                   mask_tag,
    input  l1_cache_pkg::byte_en_t mask_data0,
    input  l1_cache_pkg::byte_en_t mask_data1,
    output logic                   rd_valid,
    output logic                   rd_dirty,
    output l1_cache_pkg::tag_t     rd_tag,
    output l1_cache_pkg::word_t    rd_data0,
    output l1_cache_pkg::word_t    rd_data1
);

    logic                valid_q [l1_cache_pkg::N_SETS];
    logic                dirty_q [l1_cache_pkg::N_SETS];
    l1_cache_pkg::tag_t  tag_q   [l1_cache_pkg::N_SETS];
    l1_cache_pkg::word_t data0_q [l1_cache_pkg::N_SETS];
    l1_cache_pkg::word_t data1_q [l1_cache_pkg::N_SETS];

    // combinational read of the indexed set
    assign rd_valid = valid_q[set_sel];
    assign rd_dirty = dirty_q[set_sel];
    assign rd_tag   = tag_q[set_sel];
    assign rd_data0 = data0_q[set_sel];
    assign rd_data1 = data1_q[set_sel];

    // status bits
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < l1_cache_pkg::N_SETS; i++) begin
                valid_q[i] <= 1'b0;
                dirty_q[i] <= 1'b0;
            end
        end else if (wr_en) begin
            if (mask_valid)
                valid_q[set_sel] <= wr_valid;
            if (mask_dirty)
                dirty_q[set_sel] <= wr_dirty;
        end
    end

    // tag and block data, written per byte lane
    always_ff @(posedge CLK) begin
        if (wr_en) begin
            if (mask_tag)
                tag_q[set_sel] <= wr_tag;
            for (int b = 0; b < l1_cache_pkg::WORD_W / 8; b++) begin
                if (mask_data0[b])
                    data0_q[set_sel][8*b +: 8] <= wr_data0[8*b +: 8];
                if (mask_data1[b])
                    data1_q[set_sel][8*b +: 8] <= wr_data1[8*b +: 8];
            end
        end
    end

    // a frame marked dirty must still be valid after the write
    a_dirty_implies_valid: assert property (@(posedge CLK) disable iff (!nRST)
        (wr_en && mask_dirty && wr_dirty) |=> valid_q[$past(set_sel)]);

endmodule

`default_nettype wire

// File: logic/cache_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module cache_sequencer (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    word_en,
    input  logic                    word_clr,
    input  logic                    walk_en,
    input  logic                    walk_clr,
    output l1_cache_pkg::word_sel_t word_cnt,
    output logic                    word_last,
    output l1_cache_pkg::set_idx_t  walk_set,
    output l1_cache_pkg::word_sel_t walk_word,
    output logic                    walk_finish
);

    logic set_step;     // walker moves on to the next set

    // word counter for fills and write-backs
    assign word_last = (word_cnt == l1_cache_pkg::LAST_WORD);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            word_cnt <= '0;
        end else if (word_clr) begin
            word_cnt <= '0;
        end else if (word_en) begin
            word_cnt <= word_cnt + l1_cache_pkg::word_sel_t'(1);
        end
    end

    // stepping from the last word ends the set
    // word_clr together with walk_en skips the rest of the set in one step
    assign set_step = walk_en && ((walk_word == l1_cache_pkg::LAST_WORD) || word_clr);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            walk_set    <= '0;
            walk_word   <= '0;
            walk_finish <= 1'b0;
        end else if (walk_clr) begin
            walk_set    <= '0;
            walk_word   <= '0;
            walk_finish <= 1'b0;
        end else if (walk_en) begin
            if (set_step) begin
                walk_word <= '0;
                walk_set  <= walk_set + l1_cache_pkg::set_idx_t'(1); // wraps to 0 at the end
                if (walk_set == l1_cache_pkg::set_idx_t'(l1_cache_pkg::N_SETS - 1))
                    walk_finish <= 1'b1;
            end else begin
                walk_word <= walk_word + l1_cache_pkg::word_sel_t'(1);
            end
        end
    end

    // a finished walker stays parked until cleared
    a_walk_parked: assert property (@(posedge CLK) disable iff (!nRST)
        (walk_finish && !walk_clr) |=>
            (walk_finish && $stable(walk_set) && $stable(walk_word)));

endmodule

`default_nettype wire

// File: logic/cache_controller.sv
`timescale 1ns/1ns
`default_nettype none

module cache_controller (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      flush,
    output logic                      flush_done,
    input  logic                      proc_ren,
    input  logic                      proc_wen,
    input  l1_cache_pkg::addr_t       proc_addr,
    input  l1_cache_pkg::word_t       proc_wdata,
    input  l1_cache_pkg::byte_en_t    proc_byte_en,
    output l1_cache_pkg::word_t       proc_rdata,
    output logic                      proc_busy,
    output logic                      mem_ren,
    output logic                      mem_wen,
    output l1_cache_pkg::addr_t       mem_addr,
    output l1_cache_pkg::word_t       mem_wdata,
    output l1_cache_pkg::byte_en_t    mem_byte_en,
    input  l1_cache_pkg::word_t       mem_rdata,
    input  logic                      mem_busy,
    output l1_cache_pkg::set_idx_t    set_sel,
    output logic                      wr_en,
    output logic                      wr_valid,
    output logic                      wr_dirty,
    output l1_cache_pkg::tag_t        wr_tag,
    output l1_cache_pkg::word_t       wr_data0,
    output l1_cache_pkg::word_t       wr_data1,
    output logic                      mask_valid,
    output logic                      mask_dirty,
    output logic                      mask_tag,
    output l1_cache_pkg::byte_en_t    mask_data0,
    output l1_cache_pkg::byte_en_t    mask_data1,
    input  logic                      rd_valid,
    input  logic                      rd_dirty,
    input  l1_cache_pkg::tag_t        rd_tag,
    input  l1_cache_pkg::word_t       rd_data0,
    input  l1_cache_pkg::word_t       rd_data1,
    input  l1_cache_pkg::word_sel_t   word_cnt,
    input  logic                      word_last,
    input  l1_cache_pkg::set_idx_t    walk_set,
    input  l1_cache_pkg::word_sel_t   walk_word,
    input  logic                      walk_finish,
    output logic                      word_en,
    output logic                      word_clr,
    output logic                      walk_en,
    output logic                      walk_clr
);

    localparam int ADDR_LO = l1_cache_pkg::BYTE_BITS + l1_cache_pkg::BLOCK_BITS;

    l1_cache_pkg::cache_state_t state, next_state;
    l1_cache_pkg::tag_t         req_tag, miss_tag;
    l1_cache_pkg::set_idx_t     req_set, miss_set;
    l1_cache_pkg::word_sel_t    req_word;
    l1_cache_pkg::addr_t        miss_addr;
    logic                       miss_load;
    logic                       flush_pend;
    logic                       flush_req;
    logic                       hit;

    function automatic l1_cache_pkg::word_t pick_word(input l1_cache_pkg::word_sel_t sel,
                                                      input l1_cache_pkg::word_t w0,
                                                      input l1_cache_pkg::word_t w1);
        return (sel == l1_cache_pkg::word_sel_t'(0)) ? w0 : w1;
    endfunction

    // address fields, tag on top
    assign req_tag  = proc_addr[l1_cache_pkg::WORD_W-1 -: l1_cache_pkg::TAG_BITS];
    assign req_set  = proc_addr[ADDR_LO +: l1_cache_pkg::SET_BITS];
    assign req_word = proc_addr[l1_cache_pkg::BYTE_BITS +: l1_cache_pkg::BLOCK_BITS];
    assign miss_tag = miss_addr[l1_cache_pkg::WORD_W-1 -: l1_cache_pkg::TAG_BITS];
    assign miss_set = miss_addr[ADDR_LO +: l1_cache_pkg::SET_BITS];

    assign hit         = rd_valid && (rd_tag == req_tag);
    assign flush_req   = flush || flush_pend;
    assign proc_rdata  = pick_word(req_word, rd_data0, rd_data1);
    assign mem_byte_en = '1;   // memory only sees whole words

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= l1_cache_pkg::INIT;
            flush_pend <= 1'b0;
        end else begin
            state <= next_state;
            if (state == l1_cache_pkg::FLUSH)
                flush_pend <= 1'b0;
            else if (flush)
                flush_pend <= 1'b1;   // held until a quiet LOOKUP
        end
    end

    always_ff @(posedge CLK) begin
        if (miss_load)
            miss_addr <= proc_addr;
    end

    always_comb begin
        next_state = state;
        proc_busy  = 1'b1;
        flush_done = 1'b0;
        mem_ren    = 1'b0;
        mem_wen    = 1'b0;
        mem_addr   = '0;
        mem_wdata  = '0;
        set_sel    = miss_set;
        wr_en      = 1'b0;
        wr_valid   = 1'b0;
        wr_dirty   = 1'b0;
        wr_tag     = '0;
        wr_data0   = '0;
        wr_data1   = '0;
        mask_valid = 1'b0;
        mask_dirty = 1'b0;
        mask_tag   = 1'b0;
        mask_data0 = '0;
        mask_data1 = '0;
        word_en    = 1'b0;
        word_clr   = 1'b0;
        walk_en    = 1'b0;
        walk_clr   = 1'b0;
        miss_load  = 1'b0;

        case (state)
            l1_cache_pkg::INIT: begin
                set_sel = walk_set;
                if (walk_finish) begin
                    walk_clr   = 1'b1;
                    next_state = l1_cache_pkg::LOOKUP;
                end else begin
                    wr_en      = 1'b1;   // zero the whole frame
                    mask_valid = 1'b1;
                    mask_dirty = 1'b1;
                    mask_tag   = 1'b1;
                    mask_data0 = '1;
                    mask_data1 = '1;
                    walk_en    = 1'b1;
                    word_clr   = 1'b1;   // one set per cycle
                end
            end
            l1_cache_pkg::LOOKUP: begin
                set_sel  = req_set;
                word_clr = 1'b1;
                if (flush_req) begin
                    next_state = l1_cache_pkg::FLUSH;   // request waits behind the flush
                end else if (proc_ren || proc_wen) begin
                    if (hit) begin
                        proc_busy = 1'b0;
                        if (proc_wen) begin
                            wr_en      = 1'b1;
                            wr_dirty   = 1'b1;
                            mask_dirty = 1'b1;
                            wr_data0   = proc_wdata;
                            wr_data1   = proc_wdata;
                            mask_data0 = (req_word == '0) ? proc_byte_en : '0;
                            mask_data1 = (req_word == '0) ? '0 : proc_byte_en;
                        end
                    end else begin
                        miss_load = 1'b1;
                        if (rd_valid && rd_dirty)
                            next_state = l1_cache_pkg::WRITEBACK;
                        else
                            next_state = l1_cache_pkg::FETCH;
                    end
                end
            end
            l1_cache_pkg::FETCH: begin
                mem_ren  = 1'b1;
                mem_addr = {miss_tag, miss_set, word_cnt, {l1_cache_pkg::BYTE_BITS{1'b0}}};
                if (!mem_busy) begin
                    wr_en      = 1'b1;
                    word_en    = 1'b1;
                    wr_data0   = mem_rdata;
                    wr_data1   = mem_rdata;
                    mask_data0 = (word_cnt == '0) ? '1 : '0;
                    mask_data1 = (word_cnt == '0) ? '0 : '1;
                    if (word_last) begin
                        wr_valid   = 1'b1;   // tag and valid go in with the last word
                        wr_tag     = miss_tag;
                        mask_valid = 1'b1;
                        mask_tag   = 1'b1;
                        word_clr   = 1'b1;
                        next_state = l1_cache_pkg::LOOKUP;
                    end
                end
            end
            l1_cache_pkg::WRITEBACK: begin
                mem_wen   = 1'b1;
                mem_addr  = {rd_tag, miss_set, word_cnt, {l1_cache_pkg::BYTE_BITS{1'b0}}};
                mem_wdata = pick_word(word_cnt, rd_data0, rd_data1);
                if (!mem_busy) begin
                    word_en = 1'b1;
                    if (word_last) begin
                        wr_en      = 1'b1;   // victim now clean
                        mask_dirty = 1'b1;
                        word_clr   = 1'b1;
                        next_state = l1_cache_pkg::FETCH;
                    end
                end
            end
            l1_cache_pkg::FLUSH: begin
                set_sel = walk_set;
                if (walk_finish) begin
                    flush_done = 1'b1;
                    walk_clr   = 1'b1;
                    next_state = l1_cache_pkg::LOOKUP;
                end else if (rd_valid && rd_dirty) begin
                    mem_wen   = 1'b1;
                    mem_addr  = {rd_tag, walk_set, walk_word, {l1_cache_pkg::BYTE_BITS{1'b0}}};
                    mem_wdata = pick_word(walk_word, rd_data0, rd_data1);
                    if (!mem_busy) begin
                        walk_en = 1'b1;
                        if (walk_word == l1_cache_pkg::LAST_WORD) begin
                            wr_en      = 1'b1;
                            mask_valid = 1'b1;
                            mask_dirty = 1'b1;
                        end
                    end
                end else begin
                    wr_en      = 1'b1;   // clean or empty set, drop it
                    mask_valid = 1'b1;
                    mask_dirty = 1'b1;
                    walk_en    = 1'b1;
                    word_clr   = 1'b1;
                end
            end
            default: next_state = l1_cache_pkg::INIT;
        endcase
    end

    a_mem_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen));

    // only LOOKUP can release the processor
    a_busy_outside_lookup: assert property (@(posedge CLK) disable iff (!nRST)
        (state != l1_cache_pkg::LOOKUP) |-> proc_busy);

endmodule

`default_nettype wire

// File: logic/l1_cache.sv
`timescale 1ns/1ns
`default_nettype none

module l1_cache (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   flush,
    output logic                   flush_done,
    input  logic                   proc_ren,
    input  logic                   proc_wen,
    input  l1_cache_pkg::addr_t    proc_addr,
    input  l1_cache_pkg::word_t    proc_wdata,
    input  l1_cache_pkg::byte_en_t proc_byte_en,
    output l1_cache_pkg::word_t    proc_rdata,
    output logic                   proc_busy,
    output logic                   mem_ren,
    output logic                   mem_wen,
    output l1_cache_pkg::addr_t    mem_addr,
    output l1_cache_pkg::word_t    mem_wdata,
    output l1_cache_pkg::byte_en_t mem_byte_en,
    input  l1_cache_pkg::word_t    mem_rdata,
    input  logic                   mem_busy
);

    // frame array port
    l1_cache_pkg::set_idx_t  set_sel;
    logic                    wr_en, wr_valid, wr_dirty;
    l1_cache_pkg::tag_t      wr_tag;
    l1_cache_pkg::word_t     wr_data0, wr_data1;
    logic                    mask_valid, mask_dirty, mask_tag;
    l1_cache_pkg::byte_en_t  mask_data0, mask_data1;
    logic                    rd_valid, rd_dirty;
    l1_cache_pkg::tag_t      rd_tag;
    l1_cache_pkg::word_t     rd_data0, rd_data1;

    // sequencer port
    logic                    word_en, word_clr, walk_en, walk_clr;
    l1_cache_pkg::word_sel_t word_cnt;
    logic                    word_last;
    l1_cache_pkg::set_idx_t  walk_set;
    l1_cache_pkg::word_sel_t walk_word;
    logic                    walk_finish;

    cache_frame_array u_frames (.*);

    cache_sequencer u_seq (.*);

    cache_controller u_ctrl (.*);

endmodule

`default_nettype wire

// File: verification/mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module mem_model (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   ren,
    input  logic                   wen,
    input  l1_cache_pkg::addr_t    addr,
    input  l1_cache_pkg::word_t    wdata,
    input  l1_cache_pkg::byte_en_t byte_en,
    output l1_cache_pkg::word_t    rdata,
    output logic                   busy
);

    localparam int DEPTH = 256;
    localparam int IDX_W = $clog2(DEPTH);

    l1_cache_pkg::word_t mem_q [DEPTH];   // read directly by the testbench
    logic [IDX_W-1:0]    idx;
    logic [15:0]         lfsr_q;
    logic [1:0]          next_stall;      // stall length of the next transfer
    logic [1:0]          wait_cnt;
    logic                active;          // stall already under way

    // galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    initial begin
        for (int i = 0; i < DEPTH; i++)
            mem_q[i] = 32'h1F2E3D4C + i * 32'h01030507;
    end

    assign idx   = addr[l1_cache_pkg::BYTE_BITS +: IDX_W];
    assign rdata = mem_q[idx];
    assign busy  = (ren || wen) && (active ? (wait_cnt != 2'd0) : (next_stall != 2'd0));

    always @(posedge CLK, negedge nRST) begin : stall_ctl
        logic [15:0] s;
        logic [1:0]  pick;
        if (!nRST) begin
            lfsr_q     <= 16'd92;
            next_stall <= 2'd0;
            wait_cnt   <= 2'd0;
            active     <= 1'b0;
        end else if ((ren || wen) && !busy) begin
            s    = lfsr_q;
            pick = 2'd0;
            for (int k = 0; k < 2; k++) begin
                s    = lfsr_next(s);     // one step per bit
                pick = {pick[0], s[0]};
            end
            lfsr_q     <= s;
            next_stall <= pick;
            active     <= 1'b0;
        end else if (ren || wen) begin
            if (!active) begin
                active   <= 1'b1;
                wait_cnt <= next_stall - 2'd1;
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

    always @(posedge CLK) begin
        if (wen && !busy) begin
            for (int b = 0; b < l1_cache_pkg::WORD_W / 8; b++)
                if (byte_en[b])
                    mem_q[idx][8*b +: 8] <= wdata[8*b +: 8];
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_l1_cache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_l1_cache;

    localparam int MEM_WORDS   = 256;
    localparam int IDX_W       = $clog2(MEM_WORDS);
    localparam int PAGE_WORDS  = l1_cache_pkg::N_SETS * l1_cache_pkg::BLOCK_SIZE;
    localparam int RAND_OPS    = 200;
    localparam int N_OPS       = 40 + RAND_OPS;
    localparam int WORST_OP    = 20;   // write-back and fill of 2 words at 4 cycles, plus handshake
    localparam int CYCLE_LIMIT = 50 + N_OPS * WORST_OP + 200;

    logic                   CLK, nRST, flush, flush_done;
    logic                   proc_ren, proc_wen, proc_busy;
    l1_cache_pkg::addr_t    proc_addr;
    l1_cache_pkg::word_t    proc_wdata, proc_rdata;
    l1_cache_pkg::byte_en_t proc_byte_en;
    logic                   mem_ren, mem_wen, mem_busy;
    l1_cache_pkg::addr_t    mem_addr;
    l1_cache_pkg::word_t    mem_wdata, mem_rdata;
    l1_cache_pkg::byte_en_t mem_byte_en;

    l1_cache_pkg::word_t shadow [MEM_WORDS];
    logic [15:0]         rng;
    logic [31:0]         bits;
    string               test_name;
    int                  value_errors, other_errors, flush_pulses, cycles;

    l1_cache dut (.*);

    mem_model memory (.CLK, .nRST, .ren(mem_ren), .wen(mem_wen), .addr(mem_addr),
                      .wdata(mem_wdata), .byte_en(mem_byte_en), .rdata(mem_rdata),
                      .busy(mem_busy));

    initial CLK = 1'b0;
    always #50 CLK = ~CLK;

    function automatic l1_cache_pkg::word_t fill_word(input int i);
        return 32'h1F2E3D4C + i * 32'h01030507;
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [IDX_W-1:0] word_index(input l1_cache_pkg::addr_t a);
        return a[l1_cache_pkg::BYTE_BITS +: IDX_W];
    endfunction

    function automatic l1_cache_pkg::word_t merge_bytes(input l1_cache_pkg::word_t old,
                                                        input l1_cache_pkg::word_t data,
                                                        input l1_cache_pkg::byte_en_t be);
        l1_cache_pkg::word_t res;
        res = old;
        for (int b = 0; b < l1_cache_pkg::WORD_W / 8; b++)
            if (be[b])
                res[8*b +: 8] = data[8*b +: 8];
        return res;
    endfunction

    // expected read value from the shadow memory
    function automatic l1_cache_pkg::word_t ref_read(input l1_cache_pkg::addr_t a);
        return shadow[word_index(a)];
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int k = 0; k < n; k++) begin
            rng = lfsr_next(rng);
            val = {val[30:0], rng[0]};
        end
    endtask

    // one processor transfer, held until busy drops
    task automatic access(input logic wr, input int idx, input l1_cache_pkg::word_t data,
                          input l1_cache_pkg::byte_en_t be);
        @(posedge CLK);
        #10;
        proc_ren     = !wr;
        proc_wen     = wr;
        proc_addr    = l1_cache_pkg::addr_t'(idx) << l1_cache_pkg::BYTE_BITS;
        proc_wdata   = data;
        proc_byte_en = be;
        @(negedge CLK);
        while (proc_busy)
            @(negedge CLK);
        @(posedge CLK);
        #10;
        proc_ren = 1'b0;
        proc_wen = 1'b0;
    endtask

    task automatic pulse_flush();
        @(posedge CLK);
        #10 flush = 1'b1;
        @(posedge CLK);
        #10 flush = 1'b0;
    endtask

    // completed transfers show up here, mid-cycle
    always @(negedge CLK) begin : compare
        l1_cache_pkg::word_t expected;
        logic [IDX_W-1:0]    idx;
        if (nRST && !proc_busy && proc_ren) begin
            expected = ref_read(proc_addr);
            assert (proc_rdata === expected) else begin
                value_errors++;
                $display("FAILED %s: addr %h expected %h actual %h",
                         test_name, proc_addr, expected, proc_rdata);
            end
        end
        if (nRST && !proc_busy && proc_wen) begin
            idx         = word_index(proc_addr);
            shadow[idx] = merge_bytes(shadow[idx], proc_wdata, proc_byte_en);
        end
        if (nRST && flush_done)
            flush_pulses++;
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("errors: %0d wrong values, %0d other failures",
                     value_errors, other_errors + 1);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        nRST = 1'b0;
        flush = 1'b0;
        proc_ren = 1'b0;
        proc_wen = 1'b0;
        proc_addr = '0;
        proc_wdata = '0;
        proc_byte_en = '0;
        rng = 16'd92;
        value_errors = 0;
        other_errors = 0;
        flush_pulses = 0;
        cycles = 0;
        test_name = "reset";
        for (int i = 0; i < MEM_WORDS; i++)
            shadow[i] = fill_word(i);
        repeat (3) @(posedge CLK);
        #10 nRST = 1'b1;
        @(negedge CLK);
        assert (proc_busy && !mem_ren && !mem_wen && !flush_done) else begin
            other_errors++;
            $display("outputs not idle with busy high after reset");
        end

        test_name = "fill";
        for (int i = 0; i < 8; i++)
            access(1'b0, i, '0, '1);
        access(1'b0, 100, '0, '1);
        access(1'b0, 101, '0, '1);

        test_name = "byte_mask";
        access(1'b1, 2, 32'hDEADBEEF, 4'b0101);
        access(1'b0, 2, '0, '1);
        access(1'b1, 3, 32'h12345678, 4'b1000);
        access(1'b0, 3, '0, '1);
        access(1'b1, 2, 32'hCAFEF00D, 4'b0010);
        access(1'b0, 2, '0, '1);

        test_name = "writeback";
        access(1'b1, 4, 32'hA5A55A5A, '1);
        access(1'b0, 4 + PAGE_WORDS, '0, '1);  // same set, other tag
        access(1'b0, 4, '0, '1);

        test_name = "flush";
        access(1'b1, 10, 32'h0BADCAFE, '1);
        access(1'b1, 21, 32'h55AA33CC, 4'b0110);
        access(1'b1, 40, 32'h87654321, 4'b0011);
        access(1'b1, 63, 32'hFEEDFACE, '1);
        pulse_flush();
        while (flush_pulses == 0)
            @(negedge CLK);
        repeat (3) @(posedge CLK);
        assert (flush_pulses == 1) else begin
            other_errors++;
            $display("flush_done pulsed %0d times instead of once", flush_pulses);
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            assert (memory.mem_q[i] === shadow[i]) else begin
                value_errors++;
                $display("FAILED %s: word %0d expected %h actual %h",
                         test_name, i, shadow[i], memory.mem_q[i]);
            end
        end

        test_name = "random";
        for (int n = 0; n < RAND_OPS; n++) begin : rand_op
            logic                   wr;
            int                     idx;
            l1_cache_pkg::byte_en_t be;
            take_bits(1, bits);
            wr = bits[0];
            take_bits(6, bits);
            idx = int'(bits[5:0]);   // 64 words, two tags per set
            take_bits(4, bits);
            be = bits[3:0];
            take_bits(32, bits);
            access(wr, idx, bits, wr ? be : '1);
        end

        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
logic/l1_cache_pkg.sv
logic/cache_frame_array.sv
logic/cache_sequencer.sv
logic/cache_controller.sv
logic/l1_cache.sv
verification/mem_model.sv
verification/tb_l1_cache.sv

// File: Makefile
VERILATOR  = verilator
FILELIST   = project.f
TOP        = tb_l1_cache
RTL_TOP    = l1_cache
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -j 0
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
